//--- design/timerAPkg.sv
// ####################
// shared types and register map for the interval timer
// import into any block that decodes or uses the control fields
// ####################

package timerAPkg;

    // counter operating mode, MC field
    typedef enum logic [1:0] {
        stop       = 2'b00,
        up         = 2'b01,
        continuous = 2'b10,
        upDown     = 2'b11
    } timerMode;

    // tick source select, SSEL field
    typedef enum logic [1:0] {
        extTick    = 2'b00,
        auxTick    = 2'b01,
        mainClk    = 2'b10,
        invExtTick = 2'b11
    } clockSource;

    // up/down direction state
    typedef enum logic {
        countingUp   = 1'b0,
        countingDown = 1'b1
    } countDir;

    // register offsets from the block base address
    localparam logic [15:0] ctlOffset   = 16'h0000;
    localparam logic [15:0] countOffset = 16'h0010;
    localparam logic [15:0] ccr0Offset  = 16'h0012;
    localparam logic [15:0] ex0Offset   = 16'h0020;
    localparam logic [15:0] ivOffset    = 16'h002E;

    // control register fields
    localparam int srcHi  = 9;
    localparam int srcLo  = 8;
    localparam int idHi   = 7;
    localparam int idLo   = 6;
    localparam int mcHi   = 5;
    localparam int mcLo   = 4;
    localparam int clrBit = 2;
    localparam int ieBit  = 1;
    localparam int ifgBit = 0;

    // ex0 expansion divider field
    localparam int idexHi = 2;
    localparam int idexLo = 0;

    // vector value returned while the overflow flag is pending
    localparam logic [15:0] ivOverflow = 16'h000E;

endpackage

//--- design/timerCtrlIf.sv
// ####################
// decoded control fields, register file to prescaler and counter
// ####################

interface timerCtrlIf
    import timerAPkg::*;
();

    timerMode   mode;
    clockSource source;
    logic [1:0] inputDiv;
    logic [2:0] expandDiv;
    // one-cycle restart request from the control register
    logic       clearCount;

    modport regs (
        output mode,
        output source,
        output inputDiv,
        output expandDiv,
        output clearCount
    );

    modport prescale (
        input source,
        input inputDiv,
        input expandDiv,
        input clearCount
    );

    modport counter (
        input mode,
        input clearCount
    );

endinterface

//--- design/timerARegs.sv
// ####################
// memory-mapped registers of the timer: control, TAR, ccr0, ex0, vector
// byte and word writes on memWrite, combinational read data
// ####################

module timerARegs
    import timerAPkg::*;
#(
    parameter logic [15:0] baseAddress = 16'h0340
) (
    input  logic        MCLK,
    input  logic        wTACLR,
    input  logic [15:0] addr,
    input  logic [15:0] writeData,
    input  logic        memWrite,
    input  logic        byteWrite,
    input  logic        memRead,
    input  logic        tick,
    input  logic        overflowEvent,
    input  logic [15:0] nextCount,
    output logic [15:0] readData,
    output logic [15:0] count,
    output logic [15:0] ccr0,
    output logic        irq,
    timerCtrlIf.regs    ctrl
);

    logic [15:0] ctlReg;
    logic [15:0] tarReg;
    logic [15:0] ccr0Reg;
    logic [2:0]  ex0Reg;

    logic [15:0] offset;
    logic [15:0] wrData;
    logic        loEn;
    logic        hiEn;
    logic        ivRead;
    logic [15:0] wordData;

    // replace only the enabled byte lanes
    function automatic logic [15:0] mergeWrite(
        input logic [15:0] oldVal,
        input logic [15:0] newVal,
        input logic        lowLane,
        input logic        highLane
    );
        logic [15:0] merged;
        merged[7:0]  = lowLane  ? newVal[7:0]  : oldVal[7:0];
        merged[15:8] = highLane ? newVal[15:8] : oldVal[15:8];
        return merged;
    endfunction

    // word view of the address, bit 0 only picks the byte lane
    assign offset = {addr[15:1], 1'b0} - baseAddress;
    assign loEn   = !byteWrite || !addr[0];
    assign hiEn   = !byteWrite || addr[0];
    // byte data always arrives on the low lane
    assign wrData = byteWrite ? {writeData[7:0], writeData[7:0]} : writeData;
    assign ivRead = memRead && (offset == ivOffset);

    always_ff @(posedge MCLK or posedge wTACLR) begin
        if (wTACLR) begin
            ctlReg  <= '0;
            tarReg  <= '0;
            ccr0Reg <= '0;
            ex0Reg  <= '0;
        end else begin
            // clear request lasts a single cycle
            if (ctlReg[clrBit]) begin
                ctlReg[clrBit] <= 1'b0;
            end
            if (ivRead) begin
                ctlReg[ifgBit] <= 1'b0;
            end
            if (tick) begin
                tarReg <= nextCount;
            end
            // bus writes override the counter update
            if (memWrite) begin
                case (offset)
                    ctlOffset:   ctlReg  <= mergeWrite(ctlReg, wrData, loEn, hiEn);
                    countOffset: tarReg  <= mergeWrite(tarReg, wrData, loEn, hiEn);
                    ccr0Offset:  ccr0Reg <= mergeWrite(ccr0Reg, wrData, loEn, hiEn);
                    ex0Offset: begin
                        if (loEn) begin
                            ex0Reg <= wrData[idexHi:idexLo];
                        end
                    end
                    default: begin
                    end
                endcase
            end
            // a new overflow beats a vector read in the same cycle
            if (overflowEvent) begin
                ctlReg[ifgBit] <= 1'b1;
            end
            if (ctlReg[clrBit]) begin
                tarReg <= '0;
            end
        end
    end

    always_comb begin
        case (offset)
            ctlOffset:   wordData = ctlReg;
            countOffset: wordData = tarReg;
            ccr0Offset:  wordData = ccr0Reg;
            ex0Offset:   wordData = {13'd0, ex0Reg};
            ivOffset:    wordData = ctlReg[ifgBit] ? ivOverflow : 16'h0000;
            default:     wordData = 16'h0000;
        endcase
        if (byteWrite) begin
            readData = {8'h00, addr[0] ? wordData[15:8] : wordData[7:0]};
        end else begin
            readData = wordData;
        end
    end

    assign count = tarReg;
    assign ccr0  = ccr0Reg;
    assign irq   = ctlReg[ieBit] & ctlReg[ifgBit];

    // field decode for the prescaler and counter
    assign ctrl.mode       = timerMode'(ctlReg[mcHi:mcLo]);
    assign ctrl.source     = clockSource'(ctlReg[srcHi:srcLo]);
    assign ctrl.inputDiv   = ctlReg[idHi:idLo];
    assign ctrl.expandDiv  = ex0Reg;
    assign ctrl.clearCount = ctlReg[clrBit];

endmodule

//--- design/timerAPreDiv.sv
// ####################
// tick source select and two-stage divider, ID then IDEX
// emits a single-cycle tick strobe on MCLK
// ####################

module timerAPreDiv
    import timerAPkg::*;
(
    input  logic          MCLK,
    input  logic          wTACLR,
    input  logic          extTick,
    input  logic          auxTick,
    timerCtrlIf.prescale  ctrl,
    output logic          tick
);

    logic       extTickDly;
    logic       srcEvent;
    logic [2:0] idLimit;
    logic [2:0] idCnt;
    logic [2:0] idexCnt;
    logic       idDone;
    logic       idexDone;

    // ports shadow the enum names of the same spelling, so scope them
    always_comb begin
        case (ctrl.source)
            timerAPkg::extTick:    srcEvent = extTick;
            timerAPkg::auxTick:    srcEvent = auxTick;
            timerAPkg::mainClk:    srcEvent = 1'b1;
            timerAPkg::invExtTick: srcEvent = extTickDly & ~extTick;
            default:               srcEvent = 1'b0;
        endcase
    end

    // ID divides by 1, 2, 4 or 8
    assign idLimit = (3'd1 << ctrl.inputDiv) - 3'd1;

    // compare with >= so a smaller divider takes effect at once
    assign idDone   = srcEvent && (idCnt >= idLimit);
    assign idexDone = idDone && (idexCnt >= ctrl.expandDiv);

    always_ff @(posedge MCLK or posedge wTACLR) begin
        if (wTACLR) begin
            extTickDly <= 1'b0;
            idCnt      <= '0;
            idexCnt    <= '0;
            tick       <= 1'b0;
        end else begin
            extTickDly <= extTick;
            if (ctrl.clearCount) begin
                idCnt   <= '0;
                idexCnt <= '0;
                tick    <= 1'b0;
            end else begin
                tick <= idexDone;
                if (srcEvent) begin
                    idCnt <= idDone ? 3'd0 : idCnt + 3'd1;
                end
                if (idDone) begin
                    idexCnt <= idexDone ? 3'd0 : idexCnt + 3'd1;
                end
            end
        end
    end

endmodule

//--- design/timerACount.sv
// ####################
// next-count logic for stop, up, continuous and up/down modes
// keeps the up/down direction and flags overflow and compare-0
// ####################

module timerACount
    import timerAPkg::*;
(
    input  logic         MCLK,
    input  logic         wTACLR,
    timerCtrlIf.counter  ctrl,
    input  logic         tick,
    input  logic [15:0]  count,
    input  logic [15:0]  ccr0,
    output logic [15:0]  nextCount,
    output logic         overflowEvent,
    output logic         equ0
);

    countDir dirState;
    countDir nextDir;
    logic    rawEvent;

    always_comb begin
        nextCount = count;
        nextDir   = dirState;
        rawEvent  = 1'b0;
        case (ctrl.mode)
            stop: begin
                nextCount = count;
            end
            up: begin
                // a count already past ccr0 also restarts at zero
                if (count >= ccr0) begin
                    nextCount = 16'h0000;
                    rawEvent  = 1'b1;
                end else begin
                    nextCount = count + 16'd1;
                end
            end
            continuous: begin
                nextCount = count + 16'd1;
                rawEvent  = (count == 16'hFFFF);
            end
            upDown: begin
                if (ccr0 == 16'h0000) begin
                    // no room to move, park at zero
                    nextCount = 16'h0000;
                end else if (dirState == countingUp) begin
                    if (count >= ccr0) begin
                        nextCount = count - 16'd1;
                        nextDir   = countingDown;
                    end else begin
                        nextCount = count + 16'd1;
                    end
                end else begin
                    if (count == 16'h0000) begin
                        nextCount = 16'd1;
                        nextDir   = countingUp;
                    end else begin
                        nextCount = count - 16'd1;
                        // period ends on the step down to zero
                        rawEvent  = (count == 16'd1);
                    end
                end
            end
            default: begin
                nextCount = count;
            end
        endcase
    end

    always_ff @(posedge MCLK or posedge wTACLR) begin
        if (wTACLR) begin
            dirState <= countingUp;
        end else if (ctrl.clearCount || (ctrl.mode != upDown)) begin
            dirState <= countingUp;
        end else if (tick) begin
            dirState <= nextDir;
        end
    end

    assign overflowEvent = tick & rawEvent;

    // compare unit is idle while the timer is halted
    assign equ0 = (ctrl.mode != stop) && (count == ccr0);

endmodule

//--- design/timerABase.sv
// ####################
// timer top level, registers plus prescaler plus counter
// plain bus ports, set baseAddress to place the register block
// ####################

module timerABase #(
    parameter logic [15:0] baseAddress = 16'h0340
) (
    input  logic        MCLK,
    input  logic        wTACLR,
    input  logic        extTick,
    input  logic        auxTick,
    input  logic [15:0] addr,
    input  logic [15:0] writeData,
    input  logic        memWrite,
    input  logic        byteWrite,
    input  logic        memRead,
    output logic [15:0] readData,
    output logic        irq,
    output logic        equ0
);

    logic        tick;
    logic [15:0] count;
    logic [15:0] ccr0;
    logic [15:0] nextCount;
    logic        overflowEvent;

    timerCtrlIf ctrlBus ();

    timerARegs #(
        .baseAddress(baseAddress)
    ) regs (
        .MCLK         (MCLK),
        .wTACLR       (wTACLR),
        .addr         (addr),
        .writeData    (writeData),
        .memWrite     (memWrite),
        .byteWrite    (byteWrite),
        .memRead      (memRead),
        .tick         (tick),
        .overflowEvent(overflowEvent),
        .nextCount    (nextCount),
        .readData     (readData),
        .count        (count),
        .ccr0         (ccr0),
        .irq          (irq),
        .ctrl         (ctrlBus.regs)
    );

    timerAPreDiv preDiv (
        .MCLK   (MCLK),
        .wTACLR (wTACLR),
        .extTick(extTick),
        .auxTick(auxTick),
        .ctrl   (ctrlBus.prescale),
        .tick   (tick)
    );

    timerACount counter (
        .MCLK         (MCLK),
        .wTACLR       (wTACLR),
        .ctrl         (ctrlBus.counter),
        .tick         (tick),
        .count        (count),
        .ccr0         (ccr0),
        .nextCount    (nextCount),
        .overflowEvent(overflowEvent),
        .equ0         (equ0)
    );

endmodule

//--- sim/timerABase_properties.sv
// ####################
// concurrent checks on the counter, bound into every timerACount
// ####################

module timerABaseProps
    import timerAPkg::*;
(
    input logic        MCLK,
    input logic        wTACLR,
    input logic        tick,
    input logic [15:0] count,
    input logic [15:0] ccr0,
    input logic [15:0] nextCount,
    input logic        overflowEvent,
    input countDir     dirState,
    input timerMode    mode,
    input logic        clearCount
);

    // every period ends with the count back at zero
    overflowOnTickToZero: assert property (
        @(posedge MCLK) disable iff (wTACLR)
        overflowEvent |-> tick && (nextCount == 16'h0000)
    ) else $error("overflow event without a tick or off the step to zero");

    clearZeroesCount: assert property (
        @(posedge MCLK) disable iff (wTACLR)
        clearCount |=> (count == 16'h0000)
    ) else $error("count not zero one cycle after clear");

    // only once the count is inside the period and ccr0 holds still
    upStaysBelowCcr0: assert property (
        @(posedge MCLK) disable iff (wTACLR)
        (mode == up) && ($past(mode) == up) && (ccr0 == $past(ccr0))
            && ($past(count) <= $past(ccr0)) |-> (count <= ccr0)
    ) else $error("up mode count above ccr0");

    // forced return to countingUp needs no tick
    dirChangeOnTick: assert property (
        @(posedge MCLK) disable iff (wTACLR)
        (dirState != $past(dirState)) && !$past(clearCount) && ($past(mode) == upDown)
            |-> $past(tick) && ((dirState == countingDown)
                ? ($past(count) >= $past(ccr0)) : ($past(count) == 16'h0000))
    ) else $error("direction changed without a tick at a turning point");

endmodule

bind timerACount timerABaseProps props (
    .MCLK         (MCLK),
    .wTACLR       (wTACLR),
    .tick         (tick),
    .count        (count),
    .ccr0         (ccr0),
    .nextCount    (nextCount),
    .overflowEvent(overflowEvent),
    .dirState     (dirState),
    .mode         (ctrl.mode),
    .clearCount   (ctrl.clearCount)
);

//--- sim/timerABaseTb.sv
// ####################
// directed testbench for the interval timer
// bus, tick and compare tasks drive the DUT, then five tests run in order
// ####################

module timerABaseTb
    import timerAPkg::*;
();

    localparam int clkPeriod   = 40;
    localparam int resetCycles = 16;
    localparam int upRounds    = 3;
    // rough cycle cost of each test
    localparam int regBudget     = 60;
    localparam int contBudget    = 80;
    localparam int upBudget      = upRounds * 460;
    localparam int upDownBudget  = 20 * 12 + 40;
    localparam int clearBudget   = 60;
    localparam int timeoutCycles = resetCycles + regBudget + contBudget + upBudget
                                   + upDownBudget + clearBudget + 200;

    localparam logic [15:0] baseAddr  = 16'h0340;
    localparam logic [15:0] ctlAddr   = baseAddr + ctlOffset;
    localparam logic [15:0] countAddr = baseAddr + countOffset;
    localparam logic [15:0] ccr0Addr  = baseAddr + ccr0Offset;
    localparam logic [15:0] ex0Addr   = baseAddr + ex0Offset;
    localparam logic [15:0] ivAddr    = baseAddr + ivOffset;

    logic        MCLK = 1'b0;
    logic        wTACLR;
    logic        extTick;
    logic        auxTick;
    logic [15:0] addr;
    logic [15:0] writeData;
    logic        memWrite;
    logic        byteWrite;
    logic        memRead;
    logic [15:0] readData;
    logic        irq;
    logic        equ0;
    logic [31:0] lcgState = 32'h3e89;

    timerABase #(
        .baseAddress(baseAddr)
    ) UUT (
        .MCLK     (MCLK),
        .wTACLR   (wTACLR),
        .extTick  (extTick),
        .auxTick  (auxTick),
        .addr     (addr),
        .writeData(writeData),
        .memWrite (memWrite),
        .byteWrite(byteWrite),
        .memRead  (memRead),
        .readData (readData),
        .irq      (irq),
        .equ0     (equ0)
    );

    initial begin
        forever #(clkPeriod / 2) MCLK = ~MCLK;
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired before the tests finished");
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // control word layout: source, ID, mode, clear, enable, flag
    function automatic logic [15:0] ctlWord(
        input clockSource src,
        input logic [1:0] idSel,
        input timerMode   md,
        input logic       clr,
        input logic       ie,
        input logic       ifg
    );
        return {6'd0, src, idSel, md, 1'b0, clr, ie, ifg};
    endfunction

    // up/down count after k ticks from zero
    function automatic logic [15:0] triangleCount(input int k, input int peak);
        int phase;
        phase = k % (2 * peak);
        if (phase <= peak) begin
            return 16'(phase);
        end
        return 16'(2 * peak - phase);
    endfunction

    task automatic checkWord(input string testName, input logic [15:0] expected,
                             input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", testName, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "%s returned a wrong word", testName);
        end
    endtask

    task automatic checkBit(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", testName, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "%s returned a wrong bit", testName);
        end
    endtask

    // all bus and tick tasks start and end on a falling edge
    task automatic waitCycles(input int n);
        repeat (n) @(negedge MCLK);
    endtask

    task automatic busWrite(input logic [15:0] a, input logic [15:0] data, input logic isByte);
        addr      = a;
        writeData = data;
        byteWrite = isByte;
        memWrite  = 1'b1;
        @(negedge MCLK);
        memWrite  = 1'b0;
        byteWrite = 1'b0;
        addr      = 16'h0000;
        writeData = 16'h0000;
    endtask

    task automatic busRead(input logic [15:0] a, input logic isByte, output logic [15:0] data);
        addr      = a;
        byteWrite = isByte;
        memRead   = 1'b1;
        #(clkPeriod / 4);
        data = readData;
        @(negedge MCLK);
        memRead   = 1'b0;
        byteWrite = 1'b0;
        addr      = 16'h0000;
    endtask

    // one-cycle strobes with a one-cycle gap
    task automatic pulseTicks(input logic useAux, input int n);
        for (int i = 0; i < n; i++) begin
            if (useAux) begin
                auxTick = 1'b1;
            end else begin
                extTick = 1'b1;
            end
            @(negedge MCLK);
            auxTick = 1'b0;
            extTick = 1'b0;
            @(negedge MCLK);
        end
    endtask

    task automatic registerAccess();
        logic [15:0] rd;
        busWrite(ctlAddr, 16'h02C2, 1'b0);
        busRead(ctlAddr, 1'b0, rd);
        checkWord("registerAccess ctl word", 16'h02C2, rd);
        checkBit("registerAccess irq idle", 1'b0, irq);
        busWrite(ctlAddr + 16'd1, 16'h0001, 1'b1);
        busRead(ctlAddr, 1'b0, rd);
        checkWord("registerAccess ctl high byte", 16'h01C2, rd);
        busRead(ctlAddr + 16'd1, 1'b1, rd);
        checkWord("registerAccess ctl byte read", 16'h0001, rd);
        busWrite(ccr0Addr, 16'hA5C3, 1'b0);
        busRead(ccr0Addr, 1'b0, rd);
        checkWord("registerAccess ccr0 word", 16'hA5C3, rd);
        busWrite(ccr0Addr, 16'h007E, 1'b1);
        busWrite(ccr0Addr + 16'd1, 16'h0012, 1'b1);
        busRead(ccr0Addr, 1'b0, rd);
        checkWord("registerAccess ccr0 bytes", 16'h127E, rd);
        busWrite(countAddr, 16'h1234, 1'b0);
        busWrite(countAddr + 16'd1, 16'h00BE, 1'b1);
        busRead(countAddr, 1'b0, rd);
        checkWord("registerAccess count", 16'hBE34, rd);
        busWrite(ex0Addr, 16'hFFFF, 1'b0);
        busRead(ex0Addr, 1'b0, rd);
        checkWord("registerAccess ex0", 16'h0007, rd);
        busRead(ivAddr, 1'b0, rd);
        checkWord("registerAccess vector idle", 16'h0000, rd);
        busRead(baseAddr + 16'h0004, 1'b0, rd);
        checkWord("registerAccess unmapped", 16'h0000, rd);
        busWrite(ctlAddr, 16'h0000, 1'b0);
    endtask

    task automatic continuousWrap();
        logic [15:0] rd;
        logic [15:0] start;
        logic [15:0] ctlVal;
        busWrite(ex0Addr, 16'h0000, 1'b0);
        busWrite(ctlAddr, ctlWord(mainClk, 2'd0, continuous, 1'b0, 1'b0, 1'b0), 1'b0);
        waitCycles(3);
        busRead(countAddr, 1'b0, start);
        for (int i = 1; i <= 5; i++) begin
            busRead(countAddr, 1'b0, rd);
            checkWord("continuousWrap step", start + 16'(i), rd);
        end
        busRead(ctlAddr, 1'b0, ctlVal);
        checkBit("continuousWrap flag before wrap", 1'b0, ctlVal[ifgBit]);
        busWrite(countAddr, 16'hFFF0, 1'b0);
        for (int i = 0; i < 18; i++) begin
            busRead(countAddr, 1'b0, rd);
            checkWord("continuousWrap wrap", 16'hFFF0 + 16'(i), rd);
        end
        busRead(ctlAddr, 1'b0, ctlVal);
        checkBit("continuousWrap flag", 1'b1, ctlVal[ifgBit]);
        checkBit("continuousWrap irq disabled", 1'b0, irq);
        busWrite(ctlAddr, ctlVal | (16'h0001 << ieBit), 1'b0);
        checkBit("continuousWrap irq enabled", 1'b1, irq);
        busWrite(ctlAddr, 16'h0000, 1'b0);
    endtask

    task automatic upModeDividers();
        logic [15:0] rd;
        logic [15:0] ccrVal;
        logic [1:0]  idSel;
        logic [2:0]  idexSel;
        logic [31:0] r;
        int          pulses;
        int          ticks;
        for (int round = 0; round < upRounds; round++) begin
            r       = nextRandom();
            idSel   = r[17:16];
            idexSel = r[20:18];
            ccrVal  = 16'(nextRandom() % 32'd12) + 16'd1;
            pulses  = int'(nextRandom() % 32'd200);
            ticks   = pulses / ((1 << idSel) * (int'(idexSel) + 1));
            busWrite(ctlAddr, 16'h0000, 1'b0);
            waitCycles(2);
            busWrite(ex0Addr, {13'd0, idexSel}, 1'b0);
            busWrite(ccr0Addr, ccrVal, 1'b0);
            busWrite(ctlAddr, ctlWord(timerAPkg::auxTick, idSel, up, 1'b1, 1'b0, 1'b0), 1'b0);
            waitCycles(2);
            pulseTicks(1'b1, pulses);
            waitCycles(2);
            busRead(countAddr, 1'b0, rd);
            checkWord("upModeDividers count", 16'(ticks % (int'(ccrVal) + 1)), rd);
            busRead(ctlAddr, 1'b0, rd);
            checkBit("upModeDividers flag", ticks >= int'(ccrVal) + 1, rd[ifgBit]);
        end
    endtask

    task automatic upDownTriangle();
        logic [15:0] rd;
        logic [15:0] ccrVal;
        logic [15:0] expCount;
        int          peak;
        ccrVal = 16'(nextRandom() % 32'd7) + 16'd2;
        peak   = int'(ccrVal);
        busWrite(ctlAddr, 16'h0000, 1'b0);
        waitCycles(2);
        busWrite(ex0Addr, 16'h0000, 1'b0);
        busWrite(ccr0Addr, ccrVal, 1'b0);
        busWrite(ctlAddr, ctlWord(timerAPkg::extTick, 2'd0, upDown, 1'b1, 1'b0, 1'b0), 1'b0);
        waitCycles(2);
        busRead(countAddr, 1'b0, rd);
        checkWord("upDownTriangle start", 16'h0000, rd);
        // one full period plus two steps of the next
        for (int k = 1; k <= 2 * peak + 2; k++) begin
            pulseTicks(1'b0, 1);
            waitCycles(1);
            busRead(countAddr, 1'b0, rd);
            expCount = triangleCount(k, peak);
            checkWord("upDownTriangle count", expCount, rd);
            checkBit("upDownTriangle equ0", expCount == ccrVal, equ0);
            busRead(ctlAddr, 1'b0, rd);
            checkBit("upDownTriangle flag", k >= 2 * peak, rd[ifgBit]);
        end
    endtask

    task automatic clearAndVector();
        logic [15:0] rd;
        logic [15:0] ctlVal;
        busRead(ctlAddr, 1'b0, ctlVal);
        // divide by 2, so one pulse leaves the prescaler half way
        ctlVal = ctlVal | 16'h0040 | (16'h0001 << ieBit);
        busWrite(ctlAddr, ctlVal, 1'b0);
        pulseTicks(1'b0, 1);
        busWrite(ctlAddr, ctlVal | (16'h0001 << clrBit), 1'b0);
        waitCycles(1);
        busRead(ctlAddr, 1'b0, rd);
        checkBit("clearAndVector clear bit", 1'b0, rd[clrBit]);
        busRead(countAddr, 1'b0, rd);
        checkWord("clearAndVector count cleared", 16'h0000, rd);
        pulseTicks(1'b0, 1);
        waitCycles(1);
        busRead(countAddr, 1'b0, rd);
        checkWord("clearAndVector prescaler restarted", 16'h0000, rd);
        pulseTicks(1'b0, 1);
        waitCycles(1);
        busRead(countAddr, 1'b0, rd);
        checkWord("clearAndVector first tick", 16'h0001, rd);
        checkBit("clearAndVector irq pending", 1'b1, irq);
        busRead(ivAddr, 1'b0, rd);
        checkWord("clearAndVector vector", ivOverflow, rd);
        checkBit("clearAndVector irq cleared", 1'b0, irq);
        busRead(ivAddr, 1'b0, rd);
        checkWord("clearAndVector second vector", 16'h0000, rd);
    endtask

    initial begin
        wTACLR     = 1'b1;
        extTick    = 1'b0;
        auxTick    = 1'b0;
        addr       = 16'h0000;
        writeData  = 16'h0000;
        memWrite   = 1'b0;
        byteWrite  = 1'b0;
        memRead    = 1'b0;
        repeat (resetCycles) @(negedge MCLK);
        wTACLR = 1'b0;
        registerAccess();
        continuousWrap();
        upModeDividers();
        upDownTriangle();
        clearAndVector();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- timerABase.f
design/timerAPkg.sv
design/timerCtrlIf.sv
design/timerARegs.sv
design/timerAPreDiv.sv
design/timerACount.sv
design/timerABase.sv
sim/timerABase_properties.sv
sim/timerABaseTb.sv

//--- runSim.sh
#!/bin/sh
# build the timer testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module timerABaseTb \
    -Mdir obj_dir \
    -f timerABase.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "verilator build failed with status $buildStatus"
    exit $buildStatus
fi

./obj_dir/VtimerABaseTb
simStatus=$?
if [ $simStatus -ne 0 ]; then
    echo "simulation failed with status $simStatus"
    exit $simStatus
fi

exit 0
